/* src/sq_settings.svh */
`ifndef SQ_SETTINGS_SVH
`define SQ_SETTINGS_SVH

// queue geometry
`define SQ_DEPTH    16
`define SQ_PTR_W    4
`define SQ_ALLOC_N  4   // stores allocated per cycle

// tag widths
`define SQ_TAG_W    7
`define SQ_WB_TAG_W 6   // low bits of the allocation tag

// payload
`define SQ_ADDR_W   16
`define SQ_DATA_W   16

`endif

/* src/sq_pkg.sv */
`include "sq_settings.svh"

package sq_pkg;

   typedef logic [`SQ_PTR_W-1:0] sq_ptr_t;

   typedef enum logic [1:0] {
      SQ_IDLE     = 2'b00,
      SQ_WAIT_TWO = 2'b01, // waiting for grant
      SQ_ISSUED   = 2'b10,
      SQ_WAIT_ONE = 2'b11  // waiting for the head write-back
   } sq_state_e;

   typedef struct packed {
      logic                  free;
      logic                  written;
      logic [`SQ_TAG_W-1:0]  tag;
      logic [`SQ_ADDR_W-1:0] addr;
      logic [`SQ_DATA_W-1:0] data;
   } sq_entry_t;

   typedef struct packed {
      logic                 valid;
      logic [`SQ_TAG_W-1:0] tag;
   } sq_alloc_t;

   typedef sq_alloc_t [`SQ_ALLOC_N-1:0] sq_alloc_vec_t; // slot 0 is oldest

   typedef struct packed {
      logic                    strobe;
      logic [`SQ_WB_TAG_W-1:0] tag;
      logic [`SQ_ADDR_W-1:0]   addr;
      logic [`SQ_DATA_W-1:0]   data;
   } sq_wb_t;

   typedef struct packed {
      logic [`SQ_TAG_W-1:0]  tag;
      logic [`SQ_ADDR_W-1:0] addr;
   } sq_fwd_req_t;

   typedef struct packed {
      logic                  hit;
      logic                  ready;
      logic [`SQ_DATA_W-1:0] data;
   } sq_fwd_rsp_t;

   typedef struct packed {
      logic [`SQ_ADDR_W-1:0] addr;
      logic [`SQ_DATA_W-1:0] data;
   } sq_mem_wr_t;

endpackage

/* src/sq_pointers.sv */
`timescale 1ns/1ps
`include "sq_settings.svh"

module sq_pointers import sq_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  sq_alloc_vec_t        i_alloc,
   input  logic                 i_flsh,
   input  sq_ptr_t              i_flush_ptr,
   input  logic                 i_finished,
   input  logic [`SQ_DEPTH-1:0] i_free,
   output sq_ptr_t              o_head,
   output sq_ptr_t              o_tail,
   output logic [`SQ_DEPTH-1:0] o_flush_mask,
   output logic                 o_stll
);

   logic [`SQ_ALLOC_N-1:0] vld;
   sq_ptr_t                alloc_cnt;
   sq_ptr_t                nxt_tail;
   sq_ptr_t                flush_len;
   sq_ptr_t                stll_idx;

   always_comb begin
      for (int k = 0; k < `SQ_ALLOC_N; k++) begin
         vld[k] = i_alloc[k].valid;
      end
   end

   // only patterns filled from slot 0 upward count
   always_comb begin
      case (vld)
         4'b0001: alloc_cnt = sq_ptr_t'(1);
         4'b0011: alloc_cnt = sq_ptr_t'(2);
         4'b0111: alloc_cnt = sq_ptr_t'(3);
         4'b1111: alloc_cnt = sq_ptr_t'(4);
         default: alloc_cnt = '0;
      endcase
   end

   assign nxt_tail  = o_tail + alloc_cnt;
   assign flush_len = nxt_tail - i_flush_ptr; // wraps mod depth

   // circular range [flush_ptr, nxt_tail)
   always_comb begin
      sq_ptr_t off;
      off = '0;
      for (int i = 0; i < `SQ_DEPTH; i++) begin
         off             = sq_ptr_t'(i) - i_flush_ptr;
         o_flush_mask[i] = off < flush_len;
      end
   end

   assign stll_idx = o_tail + sq_ptr_t'(`SQ_ALLOC_N);
   assign o_stll   = ~i_free[stll_idx]; // room for a full allocation group

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         o_head <= '0;
         o_tail <= '0;
      end else begin
         if (i_finished) begin
            o_head <= o_head + sq_ptr_t'(1);
         end
         o_tail <= i_flsh ? i_flush_ptr : nxt_tail; // flush overrides allocation
      end
   end

endmodule

/* src/sq_commit_fsm.sv */
`timescale 1ns/1ps

module sq_commit_fsm import sq_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic i_cmmt_str,
   input  logic i_head_written,
   input  logic i_str_grnt,
   input  logic i_done,
   output logic o_str_req,
   output logic o_str_iss,
   output logic o_finished
);

   sq_state_e state;
   sq_state_e nxt_state;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state <= SQ_IDLE;
      end else begin
         state <= nxt_state;
      end
   end

   always_comb begin
      nxt_state  = state;
      o_str_req  = 1'b0;
      o_str_iss  = 1'b0;
      o_finished = 1'b0;
      case (state)
         SQ_IDLE: begin
            if (i_cmmt_str) begin
               nxt_state = i_head_written ? SQ_WAIT_TWO : SQ_WAIT_ONE;
            end
         end
         SQ_WAIT_ONE: begin
            if (i_head_written) begin
               nxt_state = SQ_WAIT_TWO;
            end
         end
         SQ_WAIT_TWO: begin
            if (i_str_grnt) begin
               o_str_iss = 1'b1; // req drops in the one cycle issue pulse
               nxt_state = SQ_ISSUED;
            end else begin
               o_str_req = 1'b1;
            end
         end
         SQ_ISSUED: begin
            if (i_done) begin
               o_finished = 1'b1; // frees head entry at this edge
               nxt_state  = SQ_IDLE;
            end
         end
         default: nxt_state = SQ_IDLE;
      endcase
   end

endmodule

/* src/sq_entries.sv */
`timescale 1ns/1ps
`include "sq_settings.svh"

module sq_entries import sq_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  sq_alloc_vec_t        i_alloc,
   input  sq_ptr_t              i_tail,
   input  sq_ptr_t              i_head,
   input  sq_wb_t               i_wb,
   input  logic                 i_flsh,
   input  logic [`SQ_DEPTH-1:0] i_flush_mask,
   input  logic                 i_finished,
   output sq_entry_t            o_entries [`SQ_DEPTH],
   output logic [`SQ_DEPTH-1:0] o_free,
   output logic                 o_head_written,
   output sq_mem_wr_t           o_mem_wr
);

   logic [`SQ_ALLOC_N-1:0] vld;
   logic                   alloc_ok;
   logic [`SQ_DEPTH-1:0]   ins [`SQ_ALLOC_N];
   logic [`SQ_DEPTH-1:0]   commit;

   always_comb begin
      for (int k = 0; k < `SQ_ALLOC_N; k++) begin
         vld[k] = i_alloc[k].valid;
      end
   end

   assign alloc_ok = vld inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111};

   // slot k lands on entry tail+k
   always_comb begin
      sq_ptr_t idx;
      idx = '0;
      for (int k = 0; k < `SQ_ALLOC_N; k++) begin
         idx         = i_tail + sq_ptr_t'(k);
         ins[k]      = '0;
         ins[k][idx] = vld[k] & alloc_ok;
      end
   end

   assign commit = {{(`SQ_DEPTH-1){1'b0}}, i_finished} << i_head;

   for (genvar i = 0; i < `SQ_DEPTH; i++) begin : g_ent
      logic                  free_q;
      logic                  written_q;
      logic [`SQ_TAG_W-1:0]  tag_q;
      logic [`SQ_ADDR_W-1:0] addr_q;
      logic [`SQ_DATA_W-1:0] data_q;
      logic                  kill;
      logic                  alloc_hit;
      logic [`SQ_TAG_W-1:0]  alloc_tag;
      logic                  wb_hit;

      always_comb begin
         alloc_hit = 1'b0;
         alloc_tag = '0;
         for (int k = 0; k < `SQ_ALLOC_N; k++) begin
            if (ins[k][i]) begin
               alloc_hit = 1'b1;
               alloc_tag = i_alloc[k].tag;
            end
         end
      end

      assign kill   = i_flsh & i_flush_mask[i];
      assign wb_hit = i_wb.strobe & ~free_q & (tag_q[`SQ_WB_TAG_W-1:0] == i_wb.tag);

      // priority flush, commit, allocate, write-back
      always_ff @(posedge clk or negedge rst) begin
         if (!rst) begin
            free_q    <= 1'b1;
            written_q <= 1'b0;
         end else if (kill | commit[i]) begin
            free_q    <= 1'b1;
            written_q <= 1'b0;
         end else if (alloc_hit) begin
            free_q    <= 1'b0;
            written_q <= 1'b0;
         end else if (wb_hit) begin
            written_q <= 1'b1;
         end
      end

      always_ff @(posedge clk) begin
         if (kill) begin
            tag_q <= '0;
         end else if (alloc_hit & ~commit[i]) begin
            tag_q <= alloc_tag;
         end
         if (wb_hit & ~kill & ~commit[i] & ~alloc_hit) begin
            addr_q <= i_wb.addr;
            data_q <= i_wb.data;
         end
      end

      assign o_entries[i] = '{free: free_q, written: written_q, tag: tag_q,
                              addr: addr_q, data: data_q};
      assign o_free[i]    = free_q;
   end

   assign o_head_written = o_entries[i_head].written;
   assign o_mem_wr.addr  = o_entries[i_head].addr;
   assign o_mem_wr.data  = o_entries[i_head].data;

endmodule

/* src/sq_forward.sv */
`timescale 1ns/1ps
`include "sq_settings.svh"

module sq_forward import sq_pkg::*; (
   input  sq_entry_t   i_entries [`SQ_DEPTH],
   input  sq_ptr_t     i_head,
   input  sq_fwd_req_t i_fwd_req,
   output sq_fwd_rsp_t o_fwd_rsp
);

   logic [`SQ_DEPTH-1:0] older;
   logic [`SQ_DEPTH-1:0] match;
   logic [`SQ_DEPTH-1:0] rdy;
   logic [`SQ_DEPTH-1:0] shifted;
   sq_ptr_t              sel;

   always_comb begin
      for (int i = 0; i < `SQ_DEPTH; i++) begin
         older[i] = i_entries[i].tag < i_fwd_req.tag; // plain unsigned age
         match[i] = ~i_entries[i].free & older[i]
                    & (i_entries[i].addr == i_fwd_req.addr);
         rdy[i]   = i_entries[i].free | i_entries[i].written | ~older[i];
      end
   end

   // bit 0 is head, higher bits are younger
   assign shifted = (match >> i_head) | (match << (`SQ_DEPTH - i_head));

   // youngest older store wins
   always_comb begin
      sq_ptr_t off;
      off = '0;
      for (int j = 0; j < `SQ_DEPTH; j++) begin
         if (shifted[j]) begin
            off = sq_ptr_t'(j);
         end
      end
      sel = i_head + off;
   end

   assign o_fwd_rsp.hit   = |match;
   assign o_fwd_rsp.ready = &rdy;
   assign o_fwd_rsp.data  = o_fwd_rsp.hit ? i_entries[sel].data : '0;

endmodule

/* src/store_queue.sv */
`timescale 1ns/1ps
`include "sq_settings.svh"

module store_queue import sq_pkg::*; (
   input  logic          clk,
   input  logic          rst,
   input  sq_alloc_vec_t i_alloc,
   input  sq_wb_t        i_wb,
   input  logic          i_flsh,
   input  sq_ptr_t       i_flush_ptr,
   input  logic          i_cmmt_str,
   input  logic          i_str_grnt,
   input  logic          i_done,
   input  sq_fwd_req_t   i_fwd_req,
   output logic          o_stll,
   output logic          o_str_req,
   output logic          o_str_iss,
   output sq_mem_wr_t    o_mem_wr,
   output sq_fwd_rsp_t   o_fwd_rsp
);

   sq_ptr_t              head;
   sq_ptr_t              tail;
   logic [`SQ_DEPTH-1:0] free_vec;
   logic [`SQ_DEPTH-1:0] flush_mask;
   logic                 head_written;
   logic                 finished;
   sq_entry_t            entries [`SQ_DEPTH];

   sq_pointers u_ptrs (
      .clk          (clk),
      .rst          (rst),
      .i_alloc      (i_alloc),
      .i_flsh       (i_flsh),
      .i_flush_ptr  (i_flush_ptr),
      .i_finished   (finished),
      .i_free       (free_vec),
      .o_head       (head),
      .o_tail       (tail),
      .o_flush_mask (flush_mask),
      .o_stll       (o_stll)
   );

   sq_commit_fsm u_commit (
      .clk            (clk),
      .rst            (rst),
      .i_cmmt_str     (i_cmmt_str),
      .i_head_written (head_written),
      .i_str_grnt     (i_str_grnt),
      .i_done         (i_done),
      .o_str_req      (o_str_req),
      .o_str_iss      (o_str_iss),
      .o_finished     (finished)
   );

   sq_entries u_entries (
      .clk            (clk),
      .rst            (rst),
      .i_alloc        (i_alloc),
      .i_tail         (tail),
      .i_head         (head),
      .i_wb           (i_wb),
      .i_flsh         (i_flsh),
      .i_flush_mask   (flush_mask),
      .i_finished     (finished),
      .o_entries      (entries),
      .o_free         (free_vec),
      .o_head_written (head_written),
      .o_mem_wr       (o_mem_wr)
   );

   sq_forward u_fwd (
      .i_entries (entries),
      .i_head    (head),
      .i_fwd_req (i_fwd_req),
      .o_fwd_rsp (o_fwd_rsp)
   );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk; // 20 ns period
   end

   initial begin
      rst = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;
   end

endmodule

/* sim/sq_checker.sv */
`timescale 1ns/1ps
`include "sq_settings.svh"

module sq_checker import sq_pkg::*; (
   input logic          clk,
   input logic          rst,
   input sq_alloc_vec_t i_alloc,
   input sq_wb_t        i_wb,
   input logic          i_flsh,
   input sq_ptr_t       i_flush_ptr,
   input logic          i_cmmt_str,
   input logic          i_str_grnt,
   input logic          i_done,
   input logic          i_stll,
   input logic          i_str_req,
   input logic          i_str_iss,
   input sq_mem_wr_t    i_mem_wr,
   input sq_fwd_rsp_t   i_fwd_rsp,
   input logic          i_chk,
   input int            i_row,
   input logic          i_cmp_hit,
   input sq_fwd_rsp_t   i_exp
);

   int        err_cnt = 0;
   int        row_cnt = 0;
   int        row_base = 0;   // error count at the end of the previous row
   sq_entry_t m [`SQ_DEPTH]; // reference queue
   sq_ptr_t   head;
   sq_ptr_t   tail;
   int        st;             // 0 idle, 1 wait head write, 2 wait grant, 3 issued

   task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         $display("** Error %0t ns %s expected %h actual %h", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   always @(posedge clk or negedge rst) begin
      int      n;
      logic    fin;
      sq_ptr_t nt;
      sq_ptr_t off;
      logic [3:0] v;
      if (!rst) begin
         for (int i = 0; i < `SQ_DEPTH; i++) begin
            m[i] = '{free: 1'b1, written: 1'b0, tag: '0, addr: '0, data: '0};
         end
         head = '0;
         tail = '0;
         st   = 0;
      end else begin
         compare("o_stll", {31'b0, ~m[sq_ptr_t'(tail + 4'd4)].free}, {31'b0, i_stll});
         compare("o_str_req", {31'b0, st == 2 && !i_str_grnt}, {31'b0, i_str_req});
         compare("o_str_iss", {31'b0, st == 2 && i_str_grnt}, {31'b0, i_str_iss});
         if (m[head].written) begin
            compare("o_mem_wr.addr", {16'b0, m[head].addr}, {16'b0, i_mem_wr.addr});
            compare("o_mem_wr.data", {16'b0, m[head].data}, {16'b0, i_mem_wr.data});
         end
         if (i_chk) begin
            compare("o_fwd_rsp.ready", {31'b0, i_exp.ready}, {31'b0, i_fwd_rsp.ready});
            if (i_cmp_hit) begin
               compare("o_fwd_rsp.hit", {31'b0, i_exp.hit}, {31'b0, i_fwd_rsp.hit});
               compare("o_fwd_rsp.data", {16'b0, i_exp.data}, {16'b0, i_fwd_rsp.data});
            end
            row_cnt++;
            $display("row %0d %s", i_row, (err_cnt == row_base) ? "ok" : "mismatch");
            row_base = err_cnt;
         end

         // model update from the sampled inputs
         for (int k = 0; k < 4; k++) begin
            v[k] = i_alloc[k].valid;
         end
         case (v)
            4'b0001: n = 1;
            4'b0011: n = 2;
            4'b0111: n = 3;
            4'b1111: n = 4;
            default: n = 0;
         endcase
         fin = (st == 3) && i_done;
         // state moves on the head entry as it was before this edge
         case (st)
            0: if (i_cmmt_str) st = m[head].written ? 2 : 1;
            1: if (m[head].written) st = 2;
            2: if (i_str_grnt) st = 3;
            default: if (i_done) st = 0;
         endcase
         nt  = tail + sq_ptr_t'(n);
         for (int i = 0; i < `SQ_DEPTH; i++) begin
            off = sq_ptr_t'(i) - i_flush_ptr;
            if (i_flsh && off < sq_ptr_t'(nt - i_flush_ptr)) begin
               m[i].free    = 1'b1;
               m[i].written = 1'b0;
               m[i].tag     = '0;
            end else if (fin && sq_ptr_t'(i) == head) begin
               m[i].free    = 1'b1;
               m[i].written = 1'b0;
            end else if (sq_ptr_t'(i - int'(tail)) < sq_ptr_t'(n)) begin
               m[i].free    = 1'b0;
               m[i].written = 1'b0;
               m[i].tag     = i_alloc[sq_ptr_t'(i - int'(tail))].tag;
            end else if (i_wb.strobe && !m[i].free && m[i].tag[5:0] == i_wb.tag) begin
               m[i].written = 1'b1;
               m[i].addr    = i_wb.addr;
               m[i].data    = i_wb.data;
            end
         end
         if (fin) head = head + 4'd1;
         tail = i_flsh ? i_flush_ptr : nt;
      end
   end

endmodule

/* sim/tb_store_queue.sv */
`timescale 1ns/1ps
`include "sq_settings.svh"

module tb_store_queue import sq_pkg::*; ();

   localparam int K_IDLE   = 0;
   localparam int K_ALLOC  = 1;
   localparam int K_WB     = 2;
   localparam int K_FLUSH  = 3;
   localparam int K_COMMIT = 4;

   localparam logic [15:0] A = 16'h00a0;
   localparam logic [15:0] B = 16'h00b0;
   localparam logic [15:0] C = 16'h00c0;
   localparam logic [15:0] D = 16'h00d0;
   localparam logic [15:0] E = 16'h00e0;
   localparam logic [15:0] F = 16'h00f0;

   typedef struct {
      int          kind;
      int          n;      // slots to allocate
      int          tag;    // tag of slot 0
      sq_wb_t      wb;
      sq_ptr_t     fptr;
      sq_fwd_req_t req;
      logic        cmp_hit;
      sq_fwd_rsp_t exp;
   } row_t;

   logic          clk;
   logic          rst;
   sq_alloc_vec_t i_alloc;
   sq_wb_t        i_wb;
   logic          i_flsh;
   sq_ptr_t       i_flush_ptr;
   logic          i_cmmt_str;
   logic          i_str_grnt;
   logic          i_done;
   sq_fwd_req_t   i_fwd_req;
   logic          o_stll;
   logic          o_str_req;
   logic          o_str_iss;
   sq_mem_wr_t    o_mem_wr;
   sq_fwd_rsp_t   o_fwd_rsp;
   logic          chk;
   int            row_idx;
   logic          cmp_hit;
   sq_fwd_rsp_t   exp;
   logic          timed_out;
   row_t          rows [$];

   tb_clock clk0 (.clk(clk), .rst(rst));

   store_queue dut0 (
      .clk(clk), .rst(rst), .i_alloc(i_alloc), .i_wb(i_wb), .i_flsh(i_flsh),
      .i_flush_ptr(i_flush_ptr), .i_cmmt_str(i_cmmt_str), .i_str_grnt(i_str_grnt),
      .i_done(i_done), .i_fwd_req(i_fwd_req), .o_stll(o_stll), .o_str_req(o_str_req),
      .o_str_iss(o_str_iss), .o_mem_wr(o_mem_wr), .o_fwd_rsp(o_fwd_rsp)
   );

   sq_checker chk0 (
      .clk(clk), .rst(rst), .i_alloc(i_alloc), .i_wb(i_wb), .i_flsh(i_flsh),
      .i_flush_ptr(i_flush_ptr), .i_cmmt_str(i_cmmt_str), .i_str_grnt(i_str_grnt),
      .i_done(i_done), .i_stll(o_stll), .i_str_req(o_str_req), .i_str_iss(o_str_iss),
      .i_mem_wr(o_mem_wr), .i_fwd_rsp(o_fwd_rsp), .i_chk(chk), .i_row(row_idx),
      .i_cmp_hit(cmp_hit), .i_exp(exp)
   );

   function automatic void add_row(int kind, int n, int tag, int wtag, logic [15:0] waddr,
                                   logic [15:0] wdata, int fptr, int ftag,
                                   logic [15:0] faddr, logic chit, logic hit,
                                   logic rdy, logic [15:0] data);
      row_t r;
      r.kind    = kind;
      r.n       = n;
      r.tag     = tag;
      r.wb      = '{strobe: (kind == K_WB) || (kind == K_COMMIT && wtag != 0),
                    tag: 6'(wtag), addr: waddr, data: wdata};
      r.fptr    = sq_ptr_t'(fptr);
      r.req     = '{tag: 7'(ftag), addr: faddr};
      r.cmp_hit = chit;
      r.exp     = '{hit: hit, ready: rdy, data: data};
      rows.push_back(r);
   endfunction

   task automatic clear_inputs();
      i_alloc     = '0;
      i_wb        = '0;
      i_flsh      = 1'b0;
      i_flush_ptr = '0;
      i_cmmt_str  = 1'b0;
      i_str_grnt  = 1'b0;
      i_done      = 1'b0;
   endtask

   // request, random grant delay, random done delay
   task automatic run_commit(sq_wb_t wb);
      int cnt;
      int d;
      cnt = 0;
      if (wb.strobe) begin
         repeat (3) @(negedge clk); // req stays low while the head is unwritten
         i_wb = wb;
         @(negedge clk);
         i_wb = '0;
      end
      while (!o_str_req && cnt < 20) begin
         @(negedge clk);
         cnt++;
      end
      if (!o_str_req) begin
         $display("timeout: o_str_req never rose during commit at %0t ns", $time);
         timed_out = 1'b1;
      end else begin
         d = $urandom % 4;
         repeat (d) @(negedge clk);
         i_str_grnt = 1'b1;
         @(negedge clk);
         i_str_grnt = 1'b0;
         d = $urandom % 4;
         repeat (d) @(negedge clk);
         i_done = 1'b1;
         @(negedge clk);
         i_done = 1'b0;
      end
   endtask

   initial begin
      int cnt;
      void'($urandom(32'h898e));
      clear_inputs();
      i_fwd_req = '0;
      chk       = 1'b0;
      row_idx   = 0;
      cmp_hit   = 1'b0;
      exp       = '0;
      timed_out = 1'b0;
      add_row(K_IDLE,   0, 0,  0, 0, 0,       0, 100, A, 1, 0, 1, 0);
      add_row(K_ALLOC,  4, 1,  0, 0, 0,       0, 5,  A, 0, 0, 0, 0);
      add_row(K_WB,     0, 0,  1, B, 16'h1111, 0, 2,  B, 1, 1, 1, 16'h1111);
      add_row(K_WB,     0, 0,  2, A, 16'h2222, 0, 3,  A, 1, 1, 1, 16'h2222);
      add_row(K_WB,     0, 0,  3, B, 16'h3333, 0, 4,  B, 1, 1, 1, 16'h3333);
      add_row(K_WB,     0, 0,  4, A, 16'h4444, 0, 5,  A, 1, 1, 1, 16'h4444);
      add_row(K_IDLE,   0, 0,  0, 0, 0,       0, 3,  A, 1, 1, 1, 16'h2222);
      add_row(K_IDLE,   0, 0,  0, 0, 0,       0, 1,  A, 1, 0, 1, 0);
      add_row(K_ALLOC,  1, 5,  0, 0, 0,       0, 6,  C, 0, 0, 0, 0);
      add_row(K_IDLE,   0, 0,  0, 0, 0,       0, 5,  C, 1, 0, 1, 0);
      add_row(K_WB,     0, 0,  5, C, 16'h5555, 0, 6,  C, 1, 1, 1, 16'h5555);
      add_row(K_COMMIT, 0, 0,  0, 0, 0,       0, 2,  B, 1, 0, 1, 0);
      add_row(K_COMMIT, 0, 0,  0, 0, 0,       0, 3,  A, 1, 0, 1, 0);
      add_row(K_ALLOC,  1, 6,  0, 0, 0,       0, 8,  D, 0, 0, 0, 0);
      add_row(K_ALLOC,  1, 7,  0, 0, 0,       0, 8,  D, 0, 0, 0, 0);
      add_row(K_WB,     0, 0,  6, D, 16'h6666, 0, 7,  D, 1, 1, 1, 16'h6666);
      add_row(K_WB,     0, 0,  7, A, 16'h7777, 0, 8,  A, 1, 1, 1, 16'h7777);
      add_row(K_FLUSH,  0, 0,  0, 0, 0,       5, 8,  A, 1, 1, 1, 16'h4444);
      add_row(K_ALLOC,  1, 8,  0, 0, 0,       0, 9,  E, 0, 0, 0, 0);
      add_row(K_WB,     0, 0,  8, E, 16'h8888, 0, 9,  E, 1, 1, 1, 16'h8888);
      add_row(K_ALLOC,  4, 9,  0, 0, 0,       0, 13, 0, 0, 0, 0, 0);
      add_row(K_ALLOC,  4, 13, 0, 0, 0,       0, 17, 0, 0, 0, 0, 0); // stall rises
      add_row(K_COMMIT, 0, 0,  0, 0, 0,       0, 4,  B, 1, 0, 1, 0);
      add_row(K_COMMIT, 0, 0,  0, 0, 0,       0, 5,  A, 1, 0, 1, 0);
      add_row(K_COMMIT, 0, 0,  0, 0, 0,       0, 6,  C, 1, 0, 1, 0);
      add_row(K_COMMIT, 0, 0,  0, 0, 0,       0, 9,  E, 1, 0, 1, 0);
      add_row(K_COMMIT, 0, 0,  9, F, 16'h9999, 0, 10, F, 1, 0, 1, 0); // unwritten head
      cnt = 0;
      while (rst !== 1'b1 && cnt < 20) begin
         @(posedge clk);
         cnt++;
      end
      if (rst !== 1'b1) begin
         $display("timeout: reset was never released at %0t ns", $time);
         timed_out = 1'b1;
      end
      for (int r = 0; r < rows.size() && !timed_out; r++) begin
         @(negedge clk);
         case (rows[r].kind)
            K_ALLOC: begin
               for (int k = 0; k < rows[r].n; k++) begin
                  i_alloc[k] = '{valid: 1'b1, tag: 7'(rows[r].tag + k)};
               end
            end
            K_WB:     i_wb = rows[r].wb;
            K_FLUSH: begin
               i_flsh      = 1'b1;
               i_flush_ptr = rows[r].fptr;
            end
            K_COMMIT: i_cmmt_str = 1'b1;
            default:  clear_inputs();
         endcase
         @(negedge clk);
         clear_inputs();
         if (rows[r].kind == K_COMMIT) run_commit(rows[r].wb);
         i_fwd_req = rows[r].req;
         cmp_hit   = rows[r].cmp_hit;
         exp       = rows[r].exp;
         row_idx   = r;
         chk       = 1'b1;
         @(negedge clk);
         chk       = 1'b0;
         i_fwd_req = '0;
      end
      @(negedge clk);
      $display("rows checked %0d, errors %0d", chk0.row_cnt, chk0.err_cnt);
      if (timed_out || chk0.err_cnt != 0) begin
         $display("sim failed");
      end else begin
         $display("sim passed");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+src
src/sq_pkg.sv
src/sq_pointers.sv
src/sq_commit_fsm.sv
src/sq_entries.sv
src/sq_forward.sv
src/store_queue.sv
sim/tb_clock.sv
sim/sq_checker.sv
sim/tb_store_queue.sv

/* run.sh */
#!/bin/sh
# build and run the store queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f \
   --top-module tb_store_queue -o tb_store_queue

./obj_dir/tb_store_queue > sim.log 2>&1 || true
cat sim.log

grep -q "^sim passed$" sim.log
echo "result: pass"
